// File: fetch_top.f
+incdir+src
+incdir+tests
src/fetch_pix_pkg.sv
src/fetch_ext_pkg.sv
src/fetch_load_ctrl.sv
src/fetch_luma_buffer.sv
src/fetch_top.sv
tests/tb_fetch_top.sv

// File: src/fetch_config.svh
// global defines: sample width, coordinate widths, CTU geometry, beat size, load mode code
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// sample width in bits
`define PIXEL_WIDTH         8

// CTU index widths
`define PIC_X_WIDTH         8
`define PIC_Y_WIDTH         8

// CTU geometry, luma only
`define CTU_SIZE            64
`define CTU_LOG2            6

// pixels carried by one external data beat
`define BEAT_PIXELS         16

// external mode code for the current luma load
`define MODE_LOAD_CUR_LUMA  5'd1

`endif

// File: src/fetch_ext_pkg.sv
// external-bus types: CTU index, pixel coordinate, length, mode and the load state enum
`include "fetch_config.svh"

package fetch_ext_pkg;

  // CTU index as given by the system side
  typedef logic [`PIC_X_WIDTH-1:0] ctu_x_t;
  typedef logic [`PIC_Y_WIDTH-1:0] ctu_y_t;

  // pixel coordinate on the external bus
  typedef logic [`PIC_X_WIDTH+`CTU_LOG2-1:0] ext_x_t;
  typedef logic [`PIC_Y_WIDTH+`CTU_LOG2-1:0] ext_y_t;

  // request width or height
  typedef logic [7:0] ext_len_t;

  // load/store mode code
  typedef logic [4:0] ext_mode_t;

  typedef enum logic [1:0] {
    LOAD_IDLE,
    LOAD_REQ,
    LOAD_DATA,
    LOAD_DONE
  } load_state_t;

endpackage

// File: src/fetch_load_ctrl.sv
// load controller: start/done FSM, external read request and beat counter for buffer writes
`include "fetch_config.svh"

module fetch_load_ctrl (
  input  logic                      clk,
  input  logic                      rst_n_i,
  // system side
  input  logic                      sysif_start_i,
  input  fetch_ext_pkg::ctu_x_t     load_cur_luma_x_i,
  input  fetch_ext_pkg::ctu_y_t     load_cur_luma_y_i,
  output logic                      sysif_done_o,
  // external load interface
  output logic                      extif_start_o,
  output fetch_ext_pkg::ext_mode_t  extif_mode_o,
  output fetch_ext_pkg::ext_x_t     extif_x_o,
  output fetch_ext_pkg::ext_y_t     extif_y_o,
  output fetch_ext_pkg::ext_len_t   extif_width_o,
  output fetch_ext_pkg::ext_len_t   extif_height_o,
  input  logic                      extif_rden_i,
  input  fetch_pix_pkg::row_t       extif_data_i,
  input  logic                      extif_done_i,
  // buffer write side
  output logic                      wr_en_o,
  output fetch_pix_pkg::bank_sel_t  wr_bank_o,
  output fetch_pix_pkg::bank_addr_t wr_addr_o,
  output fetch_pix_pkg::row_t       wr_data_o
);

  import fetch_pix_pkg::*;
  import fetch_ext_pkg::*;

  // quarter bits per row, then row bits on top
  localparam int QTR_W = `CTU_LOG2 - $clog2(`BEAT_PIXELS);
  localparam int CNT_W = `CTU_LOG2 + QTR_W;

  load_state_t              state_q;
  load_state_t              state_d;
  logic                     start_accept;
  logic                     load_active;
  logic [CNT_W-1:0]         beat_cnt_q;
  logic                     beat_full_q;
  logic [`CTU_LOG2-1:0]     beat_row;
  logic [QTR_W-1:0]         beat_qtr;
  ext_x_t                   ext_x_q;
  ext_y_t                   ext_y_q;

  // --------------------------------------------------------------------------
  // sequencing
  // --------------------------------------------------------------------------

  assign start_accept = (state_q == LOAD_IDLE) && sysif_start_i;
  assign load_active  = (state_q == LOAD_REQ) || (state_q == LOAD_DATA);

  always_comb begin
    state_d = state_q;
    case (state_q)
      LOAD_IDLE: begin
        if (sysif_start_i) begin
          state_d = LOAD_REQ;
        end
      end
      // request pulse lasts exactly one cycle
      LOAD_REQ:  state_d = LOAD_DATA;
      LOAD_DATA: begin
        if (extif_done_i) begin
          state_d = LOAD_DONE;
        end
      end
      LOAD_DONE: state_d = LOAD_IDLE;
      default:   state_d = LOAD_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= LOAD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign extif_start_o = (state_q == LOAD_REQ);
  assign sysif_done_o  = (state_q == LOAD_DONE);

  // --------------------------------------------------------------------------
  // external request
  // --------------------------------------------------------------------------

  // CTU index to pixel position, held until the next accepted start
  always_ff @(posedge clk) begin
    if (start_accept) begin
      ext_x_q <= {load_cur_luma_x_i, {`CTU_LOG2{1'b0}}};
      ext_y_q <= {load_cur_luma_y_i, {`CTU_LOG2{1'b0}}};
    end
  end

  assign extif_x_o      = ext_x_q;
  assign extif_y_o      = ext_y_q;
  assign extif_mode_o   = `MODE_LOAD_CUR_LUMA;
  assign extif_width_o  = ext_len_t'(`CTU_SIZE);
  assign extif_height_o = ext_len_t'(`CTU_SIZE);

  // --------------------------------------------------------------------------
  // beat counter and write controls
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      beat_cnt_q  <= '0;
      beat_full_q <= 1'b0;
    end else if (start_accept) begin
      beat_cnt_q  <= '0;
      beat_full_q <= 1'b0;
    end else if (wr_en_o) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
      // last beat of the CTU, drop anything after it
      if (&beat_cnt_q) begin
        beat_full_q <= 1'b1;
      end
    end
  end

  assign beat_row = beat_cnt_q[CNT_W-1:QTR_W];
  assign beat_qtr = beat_cnt_q[QTR_W-1:0];

  assign wr_en_o   = load_active && extif_rden_i && !beat_full_q;
  assign wr_bank_o = beat_row[1:0];
  assign wr_addr_o = {beat_row[`CTU_LOG2-1:2], beat_qtr};
  assign wr_data_o = extif_data_i;

endmodule

// File: src/fetch_luma_buffer.sv
// luma buffer: four row-interleaved banks, registered block read and 4x4 slice assembly
`include "fetch_config.svh"

module fetch_luma_buffer (
  input  logic                      clk,
  input  logic                      rst_n_i,
  // write side, one beat per cycle
  input  logic                      wr_en_i,
  input  fetch_pix_pkg::bank_sel_t  wr_bank_i,
  input  fetch_pix_pkg::bank_addr_t wr_addr_i,
  input  fetch_pix_pkg::row_t       wr_data_i,
  // 4x4 block read
  input  logic                      cur_rden_i,
  input  fetch_pix_pkg::blk_coord_t cur_4x4_x_i,
  input  fetch_pix_pkg::blk_coord_t cur_4x4_y_i,
  output fetch_pix_pkg::blk_t       cur_pel_o
);

  import fetch_pix_pkg::*;

  localparam int NUM_BANKS  = 1 << $bits(bank_sel_t);
  localparam int BANK_DEPTH = 1 << $bits(bank_addr_t);
  localparam int SLICE_W    = 4 * `PIXEL_WIDTH;

  bank_addr_t   rd_addr;
  logic [1:0]   slice_q;
  pixel_t [3:0] blk_row [NUM_BANKS];

  // block row y sits in bank (y mod 4), quarter picked by x div 4
  assign rd_addr = {cur_4x4_y_i, cur_4x4_x_i[3:2]};

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slice_q <= '0;
    end else if (cur_rden_i) begin
      slice_q <= cur_4x4_x_i[1:0];
    end
  end

  // --------------------------------------------------------------------------
  // banks
  // --------------------------------------------------------------------------

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    row_t mem [BANK_DEPTH];
    row_t rd_word_q;

    always_ff @(posedge clk) begin
      if (wr_en_i && (wr_bank_i == bank_sel_t'(b))) begin
        mem[wr_addr_i] <= wr_data_i;
      end
    end

    // all banks read the same address in parallel
    always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
        rd_word_q <= '0;
      end else if (cur_rden_i) begin
        rd_word_q <= mem[rd_addr];
      end
    end

    // 4-pixel slice of this bank word, leftmost pixel lowest
    assign blk_row[b] = rd_word_q[slice_q*SLICE_W +: SLICE_W];
  end

  // --------------------------------------------------------------------------
  // block assembly
  // --------------------------------------------------------------------------

  // bank 0 is the top row of the block
  assign cur_pel_o = {blk_row[3], blk_row[2], blk_row[1], blk_row[0]};

endmodule

// File: src/fetch_pix_pkg.sv
// pixel-side types: pixel, beat row, 4x4 block, block coordinate, bank address and select
`include "fetch_config.svh"

package fetch_pix_pkg;

  // one luma sample
  typedef logic [`PIXEL_WIDTH-1:0] pixel_t;

  // one external beat, pixel 0 in the low byte
  typedef logic [`BEAT_PIXELS*`PIXEL_WIDTH-1:0] row_t;

  // one 4x4 block, block row 0 in the low 32 bits
  typedef logic [16*`PIXEL_WIDTH-1:0] blk_t;

  // 4x4 column or row index inside the CTU
  typedef logic [`CTU_LOG2-2-1:0] blk_coord_t;

  // word address inside one bank: 16 rows per bank x 4 quarters
  typedef logic [`CTU_LOG2-1:0] bank_addr_t;

  // bank index, row mod 4
  typedef logic [1:0] bank_sel_t;

endpackage

// File: src/fetch_top.sv
// fetch top: load controller and luma buffer wired to the system, external and read ports
module fetch_top (
  input  logic                      clk,
  input  logic                      rst_n_i,
  // system side
  input  logic                      sysif_start_i,
  input  fetch_ext_pkg::ctu_x_t     load_cur_luma_x_i,
  input  fetch_ext_pkg::ctu_y_t     load_cur_luma_y_i,
  output logic                      sysif_done_o,
  // external load interface
  output logic                      extif_start_o,
  output fetch_ext_pkg::ext_mode_t  extif_mode_o,
  output fetch_ext_pkg::ext_x_t     extif_x_o,
  output fetch_ext_pkg::ext_y_t     extif_y_o,
  output fetch_ext_pkg::ext_len_t   extif_width_o,
  output fetch_ext_pkg::ext_len_t   extif_height_o,
  input  logic                      extif_rden_i,
  input  fetch_pix_pkg::row_t       extif_data_i,
  input  logic                      extif_done_i,
  // 4x4 block read
  input  logic                      cur_rden_i,
  input  fetch_pix_pkg::blk_coord_t cur_4x4_x_i,
  input  fetch_pix_pkg::blk_coord_t cur_4x4_y_i,
  output fetch_pix_pkg::blk_t       cur_pel_o
);

  import fetch_pix_pkg::*;

  logic       wr_en;
  bank_sel_t  wr_bank;
  bank_addr_t wr_addr;
  row_t       wr_data;

  fetch_load_ctrl u_load_ctrl (
    .clk               ( clk               ),
    .rst_n_i           ( rst_n_i           ),
    .sysif_start_i     ( sysif_start_i     ),
    .load_cur_luma_x_i ( load_cur_luma_x_i ),
    .load_cur_luma_y_i ( load_cur_luma_y_i ),
    .sysif_done_o      ( sysif_done_o      ),
    .extif_start_o     ( extif_start_o     ),
    .extif_mode_o      ( extif_mode_o      ),
    .extif_x_o         ( extif_x_o         ),
    .extif_y_o         ( extif_y_o         ),
    .extif_width_o     ( extif_width_o     ),
    .extif_height_o    ( extif_height_o    ),
    .extif_rden_i      ( extif_rden_i      ),
    .extif_data_i      ( extif_data_i      ),
    .extif_done_i      ( extif_done_i      ),
    .wr_en_o           ( wr_en             ),
    .wr_bank_o         ( wr_bank           ),
    .wr_addr_o         ( wr_addr           ),
    .wr_data_o         ( wr_data           )
  );

  fetch_luma_buffer u_luma_buffer (
    .clk               ( clk               ),
    .rst_n_i           ( rst_n_i           ),
    .wr_en_i           ( wr_en             ),
    .wr_bank_i         ( wr_bank           ),
    .wr_addr_i         ( wr_addr           ),
    .wr_data_i         ( wr_data           ),
    .cur_rden_i        ( cur_rden_i        ),
    .cur_4x4_x_i       ( cur_4x4_x_i       ),
    .cur_4x4_y_i       ( cur_4x4_y_i       ),
    .cur_pel_o         ( cur_pel_o         )
  );

endmodule

// File: tests/fetch_tests.svh
// directed tests with their drive helpers: start pulse and checked block read

  // one-cycle start pulse for CTU (cx,cy)
  task automatic start_load(input int cx, input int cy);
    @(posedge clk);
    #1;
    load_cur_luma_x_i = ctu_x_t'(cx);
    load_cur_luma_y_i = ctu_y_t'(cy);
    sysif_start_i     = 1'b1;
    @(posedge clk);
    #1;
    sysif_start_i = 1'b0;
  endtask

  // block read, result checked one cycle after the strobe
  task automatic read_check(input string name, input int cx, input int cy,
                            input int bx, input int by);
    @(posedge clk);
    #1;
    cur_rden_i  = 1'b1;
    cur_4x4_x_i = blk_coord_t'(bx);
    cur_4x4_y_i = blk_coord_t'(by);
    @(posedge clk);
    #1;
    cur_rden_i = 1'b0;
    @(negedge clk);
    check_blk($sformatf("%s blk(%0d,%0d)", name, bx, by), exp_blk(cx, cy, bx, by),
              cur_pel_o);
  endtask

  task automatic test_reset();
    @(negedge clk);
    check_flag("reset extif_start_o", 1'b0, extif_start_o);
    check_flag("reset sysif_done_o", 1'b0, sysif_done_o);
    check_blk("reset cur_pel_o", '0, cur_pel_o);
  endtask

  task automatic test_request();
    start_load(2, 3);
    @(negedge clk);
    check_flag("request start", 1'b1, extif_start_o);
    check_coord("request x", ext_x_t'(128), extif_x_o);
    check_coord("request y", ext_x_t'(192), ext_x_t'(extif_y_o));
    check_coord("request width", ext_x_t'(64), ext_x_t'(extif_width_o));
    check_coord("request height", ext_x_t'(64), ext_x_t'(extif_height_o));
    check_coord("request mode", ext_x_t'(1), ext_x_t'(extif_mode_o));
    // single pulse only
    @(negedge clk);
    check_flag("request start length", 1'b0, extif_start_o);
    wait_pulse("request", 1'b1, 2 * LOAD_CYCLES);
  endtask

  task automatic test_full_read();
    salt = 8'h17;
    start_load(3, 2);
    wait_pulse("full_read memory side", 1'b0, 2 * LOAD_CYCLES);
    check_flag("full_read done early", 1'b0, sysif_done_o);
    @(negedge clk);
    check_flag("full_read done", 1'b1, sysif_done_o);
    @(negedge clk);
    check_flag("full_read done length", 1'b0, sysif_done_o);
    for (int by = 0; by < 16; by++) begin
      for (int bx = 0; bx < 16; bx++) begin
        read_check("full_read", 3, 2, bx, by);
      end
    end
  endtask

  task automatic test_gapped_load();
    int bx;
    int by;
    salt    = 8'hc3;
    gaps_on = 1'b1;
    start_load(5, 1);
    wait_pulse("gapped_load", 1'b1, 3 * LOAD_CYCLES);
    gaps_on = 1'b0;
    for (int i = 0; i < 64; i++) begin
      bx = int'(next_rand() % 16);
      by = int'(next_rand() % 16);
      read_check("gapped_load", 5, 1, bx, by);
    end
  endtask

  task automatic test_busy_start();
    int reqs_before;
    salt        = 8'h5a;
    reqs_before = req_count;
    start_load(7, 9);
    // second start lands well inside the data phase
    repeat (20) @(posedge clk);
    start_load(1, 1);
    wait_pulse("busy_start", 1'b1, 2 * LOAD_CYCLES);
    if (req_count != reqs_before + 1) begin
      errors++;
      $display("[ERROR] busy_start requests: expected 1, actual %0d", req_count - reqs_before);
    end
    for (int i = 0; i < 16; i++) begin
      read_check("busy_start", 7, 9, i, 15 - i);
    end
  endtask

// File: tests/tb_fetch_top.sv
// testbench top: clock, reset, DUT, memory model, xorshift, compare tasks, watchdog, summary
`include "fetch_config.svh"

module tb_fetch_top;

  import fetch_pix_pkg::*;
  import fetch_ext_pkg::*;

  // three loads of 512 cycles and 600 read cycles, twice over
  localparam int LOAD_CYCLES   = 512;
  localparam int READ_CYCLES   = 600;
  localparam int WATCHDOG_TIME = 2 * (3 * LOAD_CYCLES + READ_CYCLES) * 8;

  logic       clk               = 1'b0;
  logic       rst_n_i           = 1'b0;
  logic       sysif_start_i     = 1'b0;
  ctu_x_t     load_cur_luma_x_i = '0;
  ctu_y_t     load_cur_luma_y_i = '0;
  logic       sysif_done_o;
  logic       extif_start_o;
  ext_mode_t  extif_mode_o;
  ext_x_t     extif_x_o;
  ext_y_t     extif_y_o;
  ext_len_t   extif_width_o;
  ext_len_t   extif_height_o;
  logic       extif_rden_i      = 1'b0;
  row_t       extif_data_i      = '0;
  logic       extif_done_i      = 1'b0;
  logic       cur_rden_i        = 1'b0;
  blk_coord_t cur_4x4_x_i       = '0;
  blk_coord_t cur_4x4_y_i       = '0;
  blk_t       cur_pel_o;

  int          errors    = 0;
  int          checks    = 0;
  int          req_count = 0;
  logic [31:0] rng_state = 32'd14901;
  logic [7:0]  salt      = 8'h00;
  logic        gaps_on   = 1'b0;

  always #4 clk = ~clk;

  fetch_top i_dut (.*);

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // picture content at absolute pixel position
  function automatic pixel_t pel(input int x, input int y);
    return pixel_t'((x * 3 + y * 5 + salt) % 256);
  endfunction

  // block row r in bits [32r +: 32], leftmost pixel lowest
  function automatic blk_t exp_blk(input int cx, input int cy, input int bx, input int by);
    blk_t e;
    for (int i = 0; i < 16; i++) begin
      e[i*8 +: 8] = pel(cx * `CTU_SIZE + bx * 4 + i % 4, cy * `CTU_SIZE + by * 4 + i / 4);
    end
    return e;
  endfunction

  task automatic check_blk(input string name, input blk_t exp, input blk_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_coord(input string name, input ext_x_t exp, input ext_x_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // returns on the falling edge where the chosen done is high
  task automatic wait_pulse(input string name, input logic sys_side, input int limit);
    for (int n = 0; n < limit; n++) begin
      @(negedge clk);
      if ((sys_side ? sysif_done_o : extif_done_i) === 1'b1) begin
        return;
      end
    end
    errors++;
    $display("%s: done pulse did not arrive within %0d cycles", name, limit);
  endtask

  // request pulses seen on the external bus
  always @(negedge clk) begin
    if (extif_start_o === 1'b1) begin
      req_count++;
    end
  end

  // --------------------------------------------------------------------------
  // external memory model
  // --------------------------------------------------------------------------

  always begin : mem_model
    int gap;
    int x0;
    int y0;
    @(negedge clk);
    if (extif_start_o === 1'b1) begin
      x0 = int'(extif_x_o);
      y0 = int'(extif_y_o);
      // raster order, four beats per row
      for (int b = 0; b < 256; b++) begin
        gap = gaps_on ? int'(next_rand() % 4) : 0;
        repeat (gap + 1) begin
          @(posedge clk);
          #1;
          extif_rden_i = 1'b0;
        end
        for (int p = 0; p < `BEAT_PIXELS; p++) begin
          extif_data_i[p*8 +: 8] = pel(x0 + (b % 4) * `BEAT_PIXELS + p, y0 + b / 4);
        end
        extif_rden_i = 1'b1;
      end
      @(posedge clk);
      #1;
      extif_rden_i = 1'b0;
      extif_done_i = 1'b1;
      @(posedge clk);
      #1;
      extif_done_i = 1'b0;
    end
  end

  `include "fetch_tests.svh"

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired after %0d time units, tests did not finish", WATCHDOG_TIME);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    repeat (3) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    test_reset();
    test_request();
    test_full_read();
    test_gapped_load();
    test_busy_start();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
